// File: src/bpu_cfg_pkg.sv
`default_nettype none

package bpu_cfg_pkg;

    localparam int xlen             = 32;
    localparam int ghist_w          = 16;
    localparam int bim_entries      = 512;
    localparam int bim_idx_w        = $clog2(bim_entries);
    localparam int tag_entries      = 256;       // per tagged table
    localparam int tag_idx_w        = $clog2(tag_entries);
    localparam int tag_w            = 10;
    localparam int partial_tag_bits = 6;         // upper tag bits compared
    localparam int btb_entries      = 256;
    localparam int btb_idx_w        = $clog2(btb_entries);
    localparam int btb_tag_w        = 22;
    localparam int ras_depth        = 32;
    localparam int ras_idx_w        = $clog2(ras_depth);
    localparam int ras_ptr_w        = 6;         // extra bit tells full from empty

    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_strong_nt = 2'b00;
    localparam ctr_t ctr_weak_nt   = 2'b01;
    localparam ctr_t ctr_weak_t    = 2'b10;
    localparam ctr_t ctr_strong_t  = 2'b11;

    typedef enum logic [1:0] {bimodal, t0, t1} provider_e;

    // sent out with each prediction, handed back by execute
    typedef struct packed {
        logic [ghist_w-1:0]   history;
        provider_e            provider;
        logic [ras_ptr_w-1:0] ras_sp;
    } pred_meta_t;

    typedef struct packed {
        logic            valid;
        logic            taken;
        logic            mispredict;
        logic            is_ret;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] target;
        pred_meta_t      meta;
    } bpu_update_t;

endpackage

`default_nettype wire

// File: src/rv_inst_pkg.sv
`default_nettype none

package rv_inst_pkg;

    // major opcodes that matter for control flow
    typedef enum logic [6:0] {
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_other  = 7'b0000000
    } opcode_e;

    typedef enum logic [2:0] {
        cls_none,
        cls_cond,   // conditional branch
        cls_jal,
        cls_jalr,   // indirect jump, not a return
        cls_ret
    } inst_class_e;

    // link registers, rs1 of a return is one of these
    localparam logic [4:0] reg_ra = 5'd1;
    localparam logic [4:0] reg_t0 = 5'd5;

endpackage

`default_nettype wire

// File: src/branch_decode.sv
`default_nettype none

module branch_decode import bpu_cfg_pkg::*, rv_inst_pkg::*; (
    input  wire  [31:0]     inst_i,
    output inst_class_e     class_o,
    output logic [xlen-1:0] br_imm_o,
    output logic [xlen-1:0] jal_imm_o
);

    opcode_e opcode;
    logic    is_ret;

    always_comb begin
        case (inst_i[6:0])
            op_branch: opcode = op_branch;
            op_jal:    opcode = op_jal;
            op_jalr:   opcode = op_jalr;
            default:   opcode = op_other;
        endcase
    end

    // jalr x0, 0(ra) or jalr x0, 0(t0)
    assign is_ret = (inst_i[11:7] == 5'd0)
                 && ((inst_i[19:15] == reg_ra) || (inst_i[19:15] == reg_t0))
                 && (inst_i[31:20] == 12'd0);

    always_comb begin
        case (opcode)
            op_branch: class_o = cls_cond;
            op_jal:    class_o = cls_jal;
            op_jalr:   class_o = is_ret ? cls_ret : cls_jalr;
            default:   class_o = cls_none;
        endcase
    end

    // B-type offset
    assign br_imm_o = {{(xlen-12){inst_i[31]}}, inst_i[7], inst_i[30:25],
                       inst_i[11:8], 1'b0};
    // J-type offset
    assign jal_imm_o = {{(xlen-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};

endmodule

`default_nettype wire

// File: src/tage_predictor.sv
`default_nettype none

module tage_predictor import bpu_cfg_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire  [xlen-1:0]    pc_i,
    input  wire  bpu_update_t  upd_i,
    output logic               taken_o,
    output provider_e          provider_o,
    output logic [ghist_w-1:0] history_o
);

    typedef struct packed {
        logic [bim_idx_w-1:0] bim;
        logic [tag_idx_w-1:0] idx0;
        logic [tag_idx_w-1:0] idx1;
        logic [tag_w-1:0]     tag0;
        logic [tag_w-1:0]     tag1;
    } hash_t;

    logic [ghist_w-1:0] ghist;
    ctr_t               bim_ctr [bim_entries];
    ctr_t               t0_ctr  [tag_entries];
    ctr_t               t1_ctr  [tag_entries];
    logic [tag_w-1:0]   t0_tag  [tag_entries];
    logic [tag_w-1:0]   t1_tag  [tag_entries];
    logic               t0_vld  [tag_entries];
    logic               t1_vld  [tag_entries];

    hash_t lk;     // lookup side
    hash_t uh;     // update side, rebuilt from returned history
    logic  t0_hit, t1_hit;
    logic  alloc, alloc_t0, alloc_t1;

    // shorter history in T0 and longer in T1
    function automatic hash_t tage_hash(input logic [xlen-1:0] pc,
                                        input logic [ghist_w-1:0] h);
        hash_t r;
        r.bim  = pc[9:1];
        r.idx0 = pc[7:0] ^ h[7:0];
        r.idx1 = pc[7:0] ^ h[15:8];
        r.tag0 = pc[17:8] ^ h[15:6];
        r.tag1 = pc[17:8] ^ tag_w'(h[7:0]);
        return r;
    endfunction

    function automatic ctr_t ctr_step(input ctr_t c, input logic up);
        if (up)
            return (c == ctr_strong_t) ? c : c + 2'd1;
        else
            return (c == ctr_strong_nt) ? c : c - 2'd1;
    endfunction

    assign lk = tage_hash(pc_i, ghist);
    assign uh = tage_hash(upd_i.pc, upd_i.meta.history);

    assign t0_hit = t0_vld[lk.idx0] && (t0_tag[lk.idx0][tag_w-1 -: partial_tag_bits]
                                     == lk.tag0[tag_w-1 -: partial_tag_bits]);
    assign t1_hit = t1_vld[lk.idx1] && (t1_tag[lk.idx1][tag_w-1 -: partial_tag_bits]
                                     == lk.tag1[tag_w-1 -: partial_tag_bits]);

    always_comb begin
        if (t1_hit) begin           // longest history wins
            provider_o = t1;
            taken_o    = t1_ctr[lk.idx1][1];
        end else if (t0_hit) begin
            provider_o = t0;
            taken_o    = t0_ctr[lk.idx0][1];
        end else begin
            provider_o = bimodal;
            taken_o    = bim_ctr[lk.bim][1];
        end
    end

    assign history_o = ghist;

    // bimodal miss tries T1 first and falls back to T0
    assign alloc    = upd_i.valid && upd_i.mispredict && (upd_i.meta.provider == bimodal);
    assign alloc_t1 = alloc && (!t1_vld[uh.idx1] || (t1_tag[uh.idx1] != uh.tag1));
    assign alloc_t0 = alloc && !alloc_t1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            for (int i = 0; i < bim_entries; i++)
                bim_ctr[i] <= ctr_weak_nt;
            for (int i = 0; i < tag_entries; i++) begin
                t0_ctr[i] <= ctr_weak_nt;
                t1_ctr[i] <= ctr_weak_nt;
                t0_vld[i] <= 1'b0;
                t1_vld[i] <= 1'b0;
            end
        end else if (upd_i.valid) begin
            ghist <= {ghist[ghist_w-2:0], upd_i.taken};
            bim_ctr[uh.bim] <= ctr_step(bim_ctr[uh.bim], upd_i.taken);
            case (upd_i.meta.provider)
                t0: t0_ctr[uh.idx0] <= !upd_i.mispredict
                                     ? ctr_step(t0_ctr[uh.idx0], upd_i.taken)
                                     : (upd_i.taken ? ctr_strong_t : ctr_strong_nt);
                t1: t1_ctr[uh.idx1] <= !upd_i.mispredict
                                     ? ctr_step(t1_ctr[uh.idx1], upd_i.taken)
                                     : (upd_i.taken ? ctr_strong_t : ctr_strong_nt);
                default: ;
            endcase
            if (alloc_t1) begin
                t1_ctr[uh.idx1] <= upd_i.taken ? ctr_weak_t : ctr_weak_nt;
                t1_vld[uh.idx1] <= 1'b1;
            end
            if (alloc_t0) begin
                t0_ctr[uh.idx0] <= upd_i.taken ? ctr_weak_t : ctr_weak_nt;
                t0_vld[uh.idx0] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_t1)
            t1_tag[uh.idx1] <= uh.tag1;
        if (alloc_t0)
            t0_tag[uh.idx0] <= uh.tag0;
    end

    // a tagged provider in returned metadata must point at a live entry
    a_t0_provider: assert property (@(posedge clk) disable iff (rst)
        (upd_i.valid && (upd_i.meta.provider == t0)) |-> t0_vld[uh.idx0]);
    a_t1_provider: assert property (@(posedge clk) disable iff (rst)
        (upd_i.valid && (upd_i.meta.provider == t1)) |-> t1_vld[uh.idx1]);

endmodule

`default_nettype wire

// File: src/branch_target_buffer.sv
`default_nettype none

module branch_target_buffer import bpu_cfg_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire  [xlen-1:0]   pc_i,
    input  wire  bpu_update_t upd_i,
    output logic              hit_o,
    output logic [xlen-1:0]   target_o
);

    logic [btb_tag_w-1:0] tag_q [btb_entries];
    logic [xlen-1:0]      tgt_q [btb_entries];
    logic [btb_entries-1:0] vld_q;

    logic [btb_idx_w-1:0] idx, upd_idx;
    logic [btb_tag_w-1:0] upd_tag;
    logic                 fill;

    assign idx     = pc_i[btb_idx_w+1:2];        // word aligned
    assign upd_idx = upd_i.pc[btb_idx_w+1:2];
    assign upd_tag = upd_i.pc[xlen-1 -: btb_tag_w];
    assign fill    = upd_i.valid && upd_i.taken; // only taken flow gets an entry

    assign hit_o    = vld_q[idx] && (tag_q[idx] == pc_i[xlen-1 -: btb_tag_w]);
    assign target_o = tgt_q[idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            vld_q <= '0;
        else if (fill)
            vld_q[upd_idx] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[upd_idx] <= upd_tag;
            tgt_q[upd_idx] <= upd_i.target;
        end
    end

    // target storage has no reset, a hit needs a filled entry
    a_hit_valid: assert property (@(posedge clk) disable iff (rst)
        hit_o |-> (vld_q[idx] && !$isunknown(target_o)));

endmodule

`default_nettype wire

// File: src/return_addr_stack.sv
`default_nettype none

module return_addr_stack import bpu_cfg_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  push_i,
    input  wire                  stall_i,
    input  wire  [xlen-1:0]      push_addr_i,
    input  wire  bpu_update_t    upd_i,
    output logic [xlen-1:0]      top_o,
    output logic                 empty_o,
    output logic [ras_ptr_w-1:0] sp_o
);

    logic [xlen-1:0]      stack_q [ras_depth];
    logic [ras_ptr_w-1:0] sp_q;        // next free slot
    logic [ras_ptr_w-1:0] sp_pushed, top_ptr;
    logic                 full, do_push, do_pop, restore;

    assign full    = (sp_q == ras_ptr_w'(ras_depth));
    assign empty_o = (sp_q == '0);
    assign top_ptr = sp_q - 1'b1;
    assign top_o   = stack_q[top_ptr[ras_idx_w-1:0]];
    assign sp_o    = sp_q;

    assign do_push   = push_i && !stall_i && !full;
    assign sp_pushed = sp_q + ras_ptr_w'(do_push);
    // pop sees the stack after a same-cycle push
    assign do_pop  = upd_i.valid && upd_i.taken && upd_i.is_ret && (sp_pushed != '0);
    assign restore = upd_i.valid && upd_i.mispredict;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sp_q <= '0;
        else if (restore)
            sp_q <= upd_i.meta.ras_sp;   // overrides push and pop
        else
            sp_q <= sp_pushed - ras_ptr_w'(do_pop);
    end

    always_ff @(posedge clk) begin
        if (do_push)
            stack_q[sp_q[ras_idx_w-1:0]] <= push_addr_i;
    end

    // a restore may load any pointer from execute
    a_sp_range: assert property (@(posedge clk) disable iff (rst)
        sp_q <= ras_ptr_w'(ras_depth));

endmodule

`default_nettype wire

// File: src/bpu_top.sv
`default_nettype none

module bpu_top import bpu_cfg_pkg::*, rv_inst_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire  [xlen-1:0]   pc_i,
    input  wire  [31:0]       inst_i,
    input  wire               push_i,
    input  wire               stall_i,
    input  wire  [xlen-1:0]   push_addr_i,
    input  wire  bpu_update_t upd_i,
    output logic              is_branch_o,
    output logic              taken_o,
    output logic [xlen-1:0]   target_o,
    output pred_meta_t        meta_o
);

    inst_class_e          cls;
    logic [xlen-1:0]      br_imm, jal_imm, seq_pc;
    logic                 tage_taken;
    provider_e            provider;
    logic [ghist_w-1:0]   history;
    logic                 btb_hit;
    logic [xlen-1:0]      btb_target;
    logic [xlen-1:0]      ras_top;
    logic                 ras_empty;
    logic [ras_ptr_w-1:0] ras_sp;

    branch_decode u_decode (
        .inst_i(inst_i), .class_o(cls), .br_imm_o(br_imm), .jal_imm_o(jal_imm)
    );

    tage_predictor u_tage (
        .clk(clk), .rst(rst), .pc_i(pc_i), .upd_i(upd_i),
        .taken_o(tage_taken), .provider_o(provider), .history_o(history)
    );

    branch_target_buffer u_btb (
        .clk(clk), .rst(rst), .pc_i(pc_i), .upd_i(upd_i),
        .hit_o(btb_hit), .target_o(btb_target)
    );

    return_addr_stack u_ras (
        .clk(clk), .rst(rst), .push_i(push_i), .stall_i(stall_i),
        .push_addr_i(push_addr_i), .upd_i(upd_i),
        .top_o(ras_top), .empty_o(ras_empty), .sp_o(ras_sp)
    );

    assign seq_pc      = pc_i + xlen'(4);
    assign is_branch_o = (cls != cls_none);

    always_comb begin
        taken_o  = 1'b0;
        target_o = seq_pc;
        case (cls)
            cls_ret: begin
                taken_o  = !ras_empty;           // nothing to return to when empty
                target_o = ras_empty ? seq_pc : ras_top;
            end
            cls_jal: begin
                taken_o  = 1'b1;
                target_o = btb_hit ? btb_target : pc_i + jal_imm;
            end
            cls_cond: begin
                taken_o = tage_taken;
                if (tage_taken)
                    target_o = btb_hit ? btb_target : pc_i + br_imm;
            end
            cls_jalr: begin
                taken_o  = tage_taken;
                target_o = btb_hit ? btb_target : seq_pc;  // no static target
            end
            default: ;
        endcase
    end

    always_comb begin
        meta_o.history  = history;
        meta_o.provider = provider;
        meta_o.ras_sp   = ras_sp;
    end

endmodule

`default_nettype wire

// File: sim/bpu_tb_cases.svh
`ifndef BPU_TB_CASES_SVH
`define BPU_TB_CASES_SVH

// predict_row: name, pc, inst, exp is_branch, exp taken, exp target, exp provider
// update_row:  name, pc, taken, mispredict, is_ret, target, metadata row
// push_row:    name, return address, stall
task automatic load_cases();
    predict_row("nop",          32'h0000_1000, inst_nop, 1'b0, 1'b0, 32'h0000_1004, bimodal);
    predict_row("br_cold",      32'h0000_2000, inst_beq, 1'b1, 1'b0, 32'h0000_2004, bimodal);
    update_row ("br_resolve",   32'h0000_2000, 1'b1, 1'b0, 1'b0, 32'h0000_3000, 1);
    predict_row("br_btb",       32'h0000_2000, inst_beq, 1'b1, 1'b1, 32'h0000_3000, bimodal);
    predict_row("jal_miss",     32'h0000_4010, inst_jal, 1'b1, 1'b1, 32'h0000_4110, bimodal);
    update_row ("jal_resolve",  32'h0000_4010, 1'b1, 1'b0, 1'b0, 32'h0000_5000, 4);
    predict_row("jal_btb",      32'h0000_4010, inst_jal, 1'b1, 1'b1, 32'h0000_5000, bimodal);
    // return stack
    predict_row("ret_empty",    32'h0000_6000, inst_ret, 1'b1, 1'b0, 32'h0000_6004, bimodal);
    push_row   ("push_a",       32'h0000_7004, 1'b0);
    predict_row("ret_a",        32'h0000_6000, inst_ret, 1'b1, 1'b1, 32'h0000_7004, bimodal);
    push_row   ("push_b",       32'h0000_8008, 1'b0);
    predict_row("ret_b",        32'h0000_6000, inst_ret, 1'b1, 1'b1, 32'h0000_8008, bimodal);
    push_row   ("push_stall",   32'h0000_9000, 1'b1);
    predict_row("ret_stalled",  32'h0000_6000, inst_ret, 1'b1, 1'b1, 32'h0000_8008, bimodal);
    update_row ("ret_resolve",  32'h0000_6000, 1'b1, 1'b0, 1'b1, 32'h0000_8008, 11);
    predict_row("ret_popped",   32'h0000_6000, inst_ret, 1'b1, 1'b1, 32'h0000_7004, bimodal);
    // bimodal miss allocates into T1, history stays below 16 so the tag still matches
    predict_row("alloc_cold",   32'h0000_2040, inst_beq, 1'b1, 1'b0, 32'h0000_2044, bimodal);
    update_row ("alloc_miss",   32'h0000_2040, 1'b1, 1'b1, 1'b0, 32'h0000_2050, 16);
    predict_row("alloc_t1",     32'h0000_2040, inst_beq, 1'b1, 1'b1, 32'h0000_2050, t1);
    // pointer recovery back to the depth seen at ret_b
    push_row   ("push_c",       32'h0000_8100, 1'b0);
    push_row   ("push_d",       32'h0000_8200, 1'b0);
    predict_row("ret_d",        32'h0000_6000, inst_ret, 1'b1, 1'b1, 32'h0000_8200, bimodal);
    update_row ("recover",      32'h0000_a000, 1'b0, 1'b1, 1'b0, 32'h0000_0000, 11);
    predict_row("ret_restored", 32'h0000_6000, inst_ret, 1'b1, 1'b1, 32'h0000_8100, bimodal);
endtask

`endif

// File: sim/bpu_tb.sv
`default_nettype none

module bpu_tb import bpu_cfg_pkg::*;;

    localparam int max_rows = 32;

    // encodings used by the case table
    localparam logic [31:0] inst_nop = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [31:0] inst_beq = 32'h0000_0863;  // beq x0, x0, +16
    localparam logic [31:0] inst_jal = 32'h1000_00ef;  // jal ra, +256
    localparam logic [31:0] inst_ret = 32'h0000_8067;  // jalr x0, 0(ra)

    typedef enum logic [1:0] {act_predict, act_update, act_push} act_e;

    typedef struct packed {
        act_e            act;
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
        logic            stall;
        logic            taken;
        logic            mispredict;
        logic            is_ret;
        logic [xlen-1:0] addr;        // update target or push address
        logic [4:0]      src;         // predict row whose metadata comes back
        logic            exp_branch;
        logic            exp_taken;
        logic [xlen-1:0] exp_target;
        provider_e       exp_prov;
    } row_t;

    logic               clk;
    logic               rst;
    logic [xlen-1:0]    pc;
    logic [31:0]        inst;
    logic               push;
    logic               stall;
    logic [xlen-1:0]    push_addr;
    bpu_update_t        upd;
    logic               is_branch;
    logic               taken;
    logic [xlen-1:0]    target;
    pred_meta_t         meta;

    row_t               rows     [max_rows];
    string              names    [max_rows];
    pred_meta_t         meta_cap [max_rows];   // metadata seen on predict rows
    int                 n_rows;
    int                 errors;
    int                 checks;
    int                 cycles;
    int                 cycle_limit;
    logic [ghist_w-1:0] model_hist;
    logic [ras_ptr_w-1:0] model_sp;            // expected stack depth

    bpu_top uut (
        .clk(clk), .rst(rst), .pc_i(pc), .inst_i(inst),
        .push_i(push), .stall_i(stall), .push_addr_i(push_addr), .upd_i(upd),
        .is_branch_o(is_branch), .taken_o(taken), .target_o(target), .meta_o(meta)
    );

    always #50 clk = ~clk;

    task automatic predict_row(input string name, input logic [xlen-1:0] pc_v,
                               input logic [31:0] inst_v, input logic br, input logic tk,
                               input logic [xlen-1:0] tgt, input provider_e prov);
        row_t r;
        r            = '0;
        r.act        = act_predict;
        r.pc         = pc_v;
        r.inst       = inst_v;
        r.exp_branch = br;
        r.exp_taken  = tk;
        r.exp_target = tgt;
        r.exp_prov   = prov;
        rows[n_rows]  = r;
        names[n_rows] = name;
        n_rows++;
    endtask

    task automatic update_row(input string name, input logic [xlen-1:0] pc_v,
                              input logic tk, input logic mp, input logic ret,
                              input logic [xlen-1:0] tgt, input int src);
        row_t r;
        r            = '0;
        r.act        = act_update;
        r.pc         = pc_v;
        r.inst       = inst_nop;
        r.taken      = tk;
        r.mispredict = mp;
        r.is_ret     = ret;
        r.addr       = tgt;
        r.src        = 5'(src);
        rows[n_rows]  = r;
        names[n_rows] = name;
        n_rows++;
    endtask

    task automatic push_row(input string name, input logic [xlen-1:0] addr,
                            input logic st);
        row_t r;
        r      = '0;
        r.act  = act_push;
        r.inst = inst_nop;
        r.addr = addr;
        r.stall = st;
        rows[n_rows]  = r;
        names[n_rows] = name;
        n_rows++;
    endtask

    `include "bpu_tb_cases.svh"

    task automatic apply_row(input int i);
        row_t r;
        r         = rows[i];
        pc        = r.pc;
        inst      = r.inst;
        push      = 1'b0;
        stall     = 1'b0;
        push_addr = '0;
        upd       = '0;
        case (r.act)
            act_push: begin
                push      = 1'b1;
                stall     = r.stall;
                push_addr = r.addr;
                if (!r.stall && (model_sp < ras_ptr_w'(ras_depth)))
                    model_sp = model_sp + 1'b1;
            end
            act_update: begin
                upd.valid      = 1'b1;
                upd.taken      = r.taken;
                upd.mispredict = r.mispredict;
                upd.is_ret     = r.is_ret;
                upd.pc         = r.pc;
                upd.target     = r.addr;
                upd.meta       = meta_cap[r.src];
                model_hist     = {model_hist[ghist_w-2:0], r.taken};  // taken bit shifts in
                if (r.mispredict)
                    model_sp = meta_cap[r.src].ras_sp;   // recovery wins over a pop
                else if (r.taken && r.is_ret && (model_sp != '0))
                    model_sp = model_sp - 1'b1;
            end
            default: ;
        endcase
    endtask

    task automatic check_prediction(input int i);
        row_t r;
        r      = rows[i];
        checks += 6;
        assert (is_branch === r.exp_branch) else begin
            errors++;
            $display("error: %s is_branch expected %0b actual %0b",
                     names[i], r.exp_branch, is_branch);
        end
        assert (taken === r.exp_taken) else begin
            errors++;
            $display("error: %s taken expected %0b actual %0b", names[i], r.exp_taken, taken);
        end
        assert (target === r.exp_target) else begin
            errors++;
            $display("error: %s target expected %h actual %h", names[i], r.exp_target, target);
        end
        assert (meta.provider === r.exp_prov) else begin
            errors++;
            $display("error: %s provider expected %0d actual %0d",
                     names[i], r.exp_prov, meta.provider);
        end
        assert (meta.history === model_hist) else begin
            errors++;
            $display("error: %s history expected %h actual %h", names[i], model_hist, meta.history);
        end
        assert (meta.ras_sp === model_sp) else begin
            errors++;
            $display("error: %s ras_sp expected %0d actual %0d", names[i], model_sp, meta.ras_sp);
        end
        meta_cap[i] = meta;
    endtask

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        pc         = '0;
        inst       = inst_nop;
        push       = 1'b0;
        stall      = 1'b0;
        push_addr  = '0;
        upd        = '0;
        n_rows     = 0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        model_hist = '0;
        model_sp   = '0;
        load_cases();
        cycle_limit = n_rows * 2 + 20;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            @(negedge clk);
            apply_row(i);
            if (rows[i].act == act_predict) begin
                #40;  // just ahead of the next rising edge
                check_prediction(i);
            end
        end
        @(negedge clk);
        push = 1'b0;
        upd  = '0;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+sim
src/bpu_cfg_pkg.sv
src/rv_inst_pkg.sv
src/branch_decode.sv
src/tage_predictor.sv
src/branch_target_buffer.sv
src/return_addr_stack.sv
src/bpu_top.sv
sim/bpu_tb.sv
